// ==== hw/mem_types_pkg.sv ====
// shared memory types
// word, address, state and bus definitions

package mem_types_pkg;

  // a data or instruction word
  typedef logic [31:0] word_t;

  // word address
  typedef logic [15:0] addr_t;

  // ram port state
  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS
  } ram_state_t;

  // controller fsm
  typedef enum logic [3:0] {
    IDLE,
    ARBITER,
    SNOOP,
    WRITE_BACK_0,
    WRITE_BACK_1,
    FETCH_CACHE_0,
    FETCH_CACHE_1,
    MISS_0,
    MISS_1
  } mc_state_t;

  // from one core (icache and dcache together)
  typedef struct packed {
    logic  iren;
    logic  dren;
    logic  dwen;
    addr_t iaddr;
    addr_t daddr;
    word_t dstore;
    logic  cctrans;
    logic  ccwrite;
  } core_req_t;

  // back to one core
  typedef struct packed {
    logic  iwait;
    logic  dwait;
    word_t iload;
    word_t dload;
    logic  ccwait;
    logic  ccinv;
    addr_t ccsnoopaddr;
  } core_resp_t;

  // controller to ram
  typedef struct packed {
    logic  ren;
    logic  wen;
    addr_t addr;
    word_t store;
  } ram_req_t;

  // ram to controller
  typedef struct packed {
    word_t      load;
    ram_state_t state;
  } ram_resp_t;

endpackage

// ==== hw/memory_control.sv ====
// memory controller
// arbitration, snooping and ram routing for two cores

`timescale 1ns/100ps

module memory_control (
  input  logic                     CLK,
  input  logic                     nRST,
  input  mem_types_pkg::core_req_t  req [2],
  output mem_types_pkg::core_resp_t resp [2],
  output mem_types_pkg::ram_req_t   ram_req,
  input  mem_types_pkg::ram_resp_t  ram_resp
);
  import mem_types_pkg::*;

  mc_state_t state;
  mc_state_t next_state;
  logic      active;
  logic      next_active;
  logic      peer;
  logic      any_data;
  logic      ram_done;

  assign peer     = ~active;
  assign any_data = req[0].dren | req[0].dwen | req[1].dren | req[1].dwen;
  assign ram_done = (ram_resp.state == ACCESS);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= IDLE;
      active <= 1'b0;
    end else begin
      state  <= next_state;
      active <= next_active;
    end
  end

  // next state and active core
  always_comb begin
    next_state  = state;
    next_active = active;
    case (state)
      IDLE: begin
        if (any_data)
          next_state = ARBITER;
      end
      ARBITER: begin
        // core 0 wins a tie
        next_active = (req[0].dren || req[0].dwen) ? 1'b0 : 1'b1;
        next_state  = SNOOP;
      end
      SNOOP: begin
        if (req[active].dwen)
          next_state = WRITE_BACK_0;
        else if (req[peer].cctrans)
          next_state = FETCH_CACHE_0;
        else
          next_state = MISS_0;
      end
      WRITE_BACK_0: begin
        if (ram_done)
          next_state = WRITE_BACK_1;
      end
      WRITE_BACK_1: begin
        if (ram_done)
          next_state = IDLE;
      end
      FETCH_CACHE_0: begin
        next_state = FETCH_CACHE_1;
      end
      FETCH_CACHE_1: begin
        next_state = IDLE;
      end
      MISS_0: begin
        if (ram_done)
          next_state = MISS_1;
      end
      MISS_1: begin
        if (ram_done)
          next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // ram routing, waits and coherence signals
  always_comb begin
    ram_req = '0;
    for (int i = 0; i < 2; i++) begin
      resp[i].iwait       = 1'b1;
      resp[i].dwait       = 1'b1;
      resp[i].iload       = ram_resp.load;
      resp[i].dload       = ram_resp.load;
      resp[i].ccwait      = 1'b0;
      resp[i].ccsnoopaddr = '0;
    end

    // invalidate the other core on an announced write
    resp[0].ccinv = req[1].cctrans & req[1].ccwrite;
    resp[1].ccinv = req[0].cctrans & req[0].ccwrite;

    case (state)
      IDLE: begin
        // fetches only while no data request is waiting
        if (!any_data) begin
          if (req[0].iren) begin
            ram_req.ren   = 1'b1;
            ram_req.addr  = req[0].iaddr;
            resp[0].iwait = ~ram_done;
          end else if (req[1].iren) begin
            ram_req.ren   = 1'b1;
            ram_req.addr  = req[1].iaddr;
            resp[1].iwait = ~ram_done;
          end
        end
      end
      WRITE_BACK_0, WRITE_BACK_1: begin
        ram_req.wen        = 1'b1;
        ram_req.addr       = req[active].daddr;
        ram_req.store      = req[active].dstore;
        resp[active].dwait = ~ram_done;
      end
      MISS_0, MISS_1: begin
        ram_req.ren        = 1'b1;
        ram_req.addr       = req[active].daddr;
        resp[active].dwait = ~ram_done;
      end
      FETCH_CACHE_0, FETCH_CACHE_1: begin
        // peer supplies the word, one per cycle
        resp[active].dwait = 1'b0;
        resp[active].dload = req[peer].dstore;
      end
      default: begin
      end
    endcase

    // peer is held off while the active core owns the line
    if (state inside {SNOOP, WRITE_BACK_0, WRITE_BACK_1, FETCH_CACHE_0, FETCH_CACHE_1}) begin
      resp[peer].ccwait      = 1'b1;
      resp[peer].ccsnoopaddr = req[active].daddr;
    end
  end

  a_ram_kind: assert property (
    @(posedge CLK) disable iff (!nRST) !(ram_req.ren && ram_req.wen)
  ) else $error("ram ren and wen high together");

  a_one_grant: assert property (
    @(posedge CLK) disable iff (!nRST)
      $countones({resp[0].iwait, resp[0].dwait, resp[1].iwait, resp[1].dwait}) >= 3
  ) else $error("more than one wait low in a cycle");

  // a core must hold its request until served
  for (genvar g = 0; g < 2; g++) begin : g_hold
    a_dren_hold: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dren && resp[g].dwait) |=> (req[g].dren && $stable(req[g].daddr))
    ) else $error("core %0d dropped dren before dwait", g);

    a_dwen_hold: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dwen && resp[g].dwait) |=> (req[g].dwen && $stable(req[g].daddr))
    ) else $error("core %0d dropped dwen before dwait", g);

    a_iren_hold: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].iren && resp[g].iwait) |=> (req[g].iren && $stable(req[g].iaddr))
    ) else $error("core %0d dropped iren before iwait", g);
  end

endmodule

// ==== hw/memory_subsystem.sv ====
// memory subsystem
// controller and ram for two cores

`timescale 1ns/100ps

module memory_subsystem #(
  parameter int RAM_LAT       = 2,
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  mem_types_pkg::core_req_t  req [2],
  output mem_types_pkg::core_resp_t resp [2]
);
  import mem_types_pkg::*;

  // ram port between controller and model
  ram_req_t  ram_req;
  ram_resp_t ram_resp;

  memory_control mc_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .resp     (resp),
    .ram_req  (ram_req),
    .ram_resp (ram_resp)
  );

  ram_model #(
    .RAM_LAT       (RAM_LAT),
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) ram_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_req  (ram_req),
    .ram_resp (ram_resp)
  );

endmodule

// ==== hw/ram_model.sv ====
// ram model
// word storage behind a fixed latency

`timescale 1ns/100ps

module ram_model #(
  parameter int RAM_LAT       = 2,
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  mem_types_pkg::ram_req_t  ram_req,
  output mem_types_pkg::ram_resp_t ram_resp
);
  import mem_types_pkg::*;

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;
  // wide enough for RAM_LAT even when it is zero
  localparam int CNT_W = $clog2(RAM_LAT + 2);

  word_t mem [DEPTH];

  logic [CNT_W-1:0]         cnt;
  logic [CNT_W-1:0]         eff_cnt;
  logic                     prev_valid;
  addr_t                    prev_addr;
  logic                     prev_wen;
  logic                     active_req;
  logic                     same_req;
  logic [RAM_ADDR_BITS-1:0] idx;

  assign active_req = ram_req.ren | ram_req.wen;
  assign idx        = ram_req.addr[RAM_ADDR_BITS-1:0];

  // restart on any change of address or kind
  assign same_req = prev_valid && (prev_addr == ram_req.addr) && (prev_wen == ram_req.wen);
  assign eff_cnt  = same_req ? cnt : '0;

  always_comb begin
    ram_resp.load = mem[idx];
    if (!active_req)
      ram_resp.state = FREE;
    else if (eff_cnt == CNT_W'(RAM_LAT))
      ram_resp.state = ACCESS;
    else
      ram_resp.state = BUSY;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt        <= '0;
      prev_valid <= 1'b0;
      prev_addr  <= '0;
      prev_wen   <= 1'b0;
    end else begin
      prev_valid <= active_req;
      prev_addr  <= ram_req.addr;
      prev_wen   <= ram_req.wen;
      if (!active_req || ram_resp.state == ACCESS)
        cnt <= '0;
      else
        cnt <= eff_cnt + 1'b1;
    end
  end

  // storage starts out zeroed
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
    end else if (ram_req.wen && ram_resp.state == ACCESS) begin
      mem[idx] <= ram_req.store;
    end
  end

  a_access_req: assert property (
    @(posedge CLK) disable iff (!nRST)
      (ram_resp.state == ACCESS) |-> (ram_req.ren || ram_req.wen)
  ) else $error("ACCESS reported with no request");

endmodule

// ==== list.f ====
hw/mem_types_pkg.sv
hw/memory_control.sv
hw/ram_model.sv
hw/memory_subsystem.sv
tests/tb_memory_checks.sv
tests/tb_memory_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_memory_subsystem \
  -Mdir build \
  -f list.f

./build/Vtb_memory_subsystem

// ==== tests/tb_memory_checks.sv ====
// testbench checker
// shadow memory and port assertions

`timescale 1ns/100ps

module tb_memory_checks #(
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  mem_types_pkg::core_req_t  req [2],
  input  mem_types_pkg::core_resp_t resp [2],
  output bit                        failed
);
  import mem_types_pkg::*;

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;

  word_t shadow [DEPTH];
  word_t exp_d [2];
  word_t exp_i [2];
  logic  quiet;
  logic  any_data;

  task automatic mismatch(input string sig, input word_t exp, input word_t act);
    $display("MISMATCH %s expected %h actual %h", sig, exp, act);
    failed = 1'b1;
  endtask

  task automatic complain(input string what);
    $display("check failed: %s", what);
    failed = 1'b1;
  endtask

  // mirror of the ram, written by completed write-back words
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DEPTH; i++)
        shadow[i] <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (req[i].dwen && !resp[i].dwait)
          shadow[req[i].daddr[RAM_ADDR_BITS-1:0]] <= req[i].dstore;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      exp_d[i] = shadow[req[i].daddr[RAM_ADDR_BITS-1:0]];
      exp_i[i] = shadow[req[i].iaddr[RAM_ADDR_BITS-1:0]];
    end
  end

  assign quiet = resp[0].iwait && resp[0].dwait && resp[1].iwait && resp[1].dwait
              && !resp[0].ccwait && !resp[1].ccwait && !resp[0].ccinv && !resp[1].ccinv;
  assign any_data = req[0].dren || req[0].dwen || req[1].dren || req[1].dwen;

  a_reset_quiet: assert property (
    @(posedge CLK) (!nRST || $past(!nRST)) |-> quiet
  ) else complain("a wait was low or a coherence signal was high around reset");

  a_data_first: assert property (
    @(posedge CLK) disable iff (!nRST) any_data |-> (resp[0].iwait && resp[1].iwait)
  ) else complain("an instruction fetch was served while a data request was pending");

  // core 0 wins when both fetch
  a_fetch_prio: assert property (
    @(posedge CLK) disable iff (!nRST)
      (req[0].iren && req[1].iren && resp[0].iwait) |-> resp[1].iwait
  ) else mismatch("resp[1].iwait", word_t'(1), word_t'($sampled(resp[1].iwait)));

  for (genvar g = 0; g < 2; g++) begin : g_core
    localparam int H = 1 - g;

    a_miss_data: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dren && !resp[g].dwait && !req[H].cctrans) |-> resp[g].dload == exp_d[g]
    ) else mismatch($sformatf("resp[%0d].dload", g), $sampled(exp_d[g]),
                    $sampled(resp[g].dload));

    // peer supplies the word
    a_c2c_data: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dren && !resp[g].dwait && req[H].cctrans) |-> resp[g].dload == req[H].dstore
    ) else mismatch($sformatf("resp[%0d].dload", g), $sampled(req[H].dstore),
                    $sampled(resp[g].dload));

    a_c2c_wait: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dren && !resp[g].dwait && req[H].cctrans) |-> resp[H].ccwait
    ) else mismatch($sformatf("resp[%0d].ccwait", H), word_t'(1),
                    word_t'($sampled(resp[H].ccwait)));

    a_c2c_addr: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].dren && !resp[g].dwait && req[H].cctrans)
          |-> resp[H].ccsnoopaddr == req[g].daddr
    ) else mismatch($sformatf("resp[%0d].ccsnoopaddr", H), word_t'($sampled(req[g].daddr)),
                    word_t'($sampled(resp[H].ccsnoopaddr)));

    a_fetch_data: assert property (
      @(posedge CLK) disable iff (!nRST)
        (req[g].iren && !resp[g].iwait) |-> resp[g].iload == exp_i[g]
    ) else mismatch($sformatf("resp[%0d].iload", g), $sampled(exp_i[g]),
                    $sampled(resp[g].iload));

    a_inval: assert property (
      @(posedge CLK) disable iff (!nRST)
        resp[g].ccinv == (req[H].cctrans && req[H].ccwrite)
    ) else mismatch($sformatf("resp[%0d].ccinv", g),
                    word_t'($sampled(req[H].cctrans) & $sampled(req[H].ccwrite)),
                    word_t'($sampled(resp[g].ccinv)));
  end

endmodule

// ==== tests/tb_memory_subsystem.sv ====
// memory subsystem testbench
// cache agents with directed and random traffic

`timescale 1ns/100ps

module tb_memory_subsystem;
  import mem_types_pkg::*;

  localparam int    RAM_LAT       = 2;
  localparam int    RAM_ADDR_BITS = 10;
  localparam int    PERIOD        = 40;
  localparam int    DRIVE_DLY     = 2;
  localparam int    N_RANDOM      = 40;
  // directed part is about 16 transactions
  localparam int    N_TRANS       = 16 + 2 * N_RANDOM;
  localparam int    WATCHDOG_NS   = N_TRANS * (2 * (RAM_LAT + 1) + 8) * PERIOD;
  localparam int    BLOCK_LAT     = 2 + 2 * (RAM_LAT + 1);
  localparam addr_t ADDR_MASK     = addr_t'(2 ** RAM_ADDR_BITS - 1);

  logic       CLK;
  logic       nRST;
  core_req_t  req [2];
  core_resp_t resp [2];
  bit         chk_failed;
  bit         tb_error;
  bit         tests_done;
  integer     seed;

  memory_subsystem #(
    .RAM_LAT       (RAM_LAT),
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) dut_i (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .resp (resp)
  );

  tb_memory_checks #(
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) chk_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .req    (req),
    .resp   (resp),
    .failed (chk_failed)
  );

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'(rand_word()) & ADDR_MASK;
  endfunction

  // counts edges until the wait is seen low before an edge
  task automatic wait_served(input bit c, input bit instr, inout int edges);
    bit waiting;
    waiting = 1'b1;
    while (waiting) begin
      @(negedge CLK);
      waiting = instr ? resp[c].iwait : resp[c].dwait;
      @(posedge CLK);
      #DRIVE_DLY;
      edges++;
    end
  endtask

  task automatic fetch_word(input bit c, input addr_t a, output int lat);
    int edges;
    edges = 0;
    req[c].iaddr = a;
    req[c].iren  = 1'b1;
    wait_served(c, 1'b1, edges);
    req[c].iren = 1'b0;
    lat = edges;
  endtask

  // two-word block, the peer answers the snoop when hit is set
  task automatic data_block(input bit c, input bit wr, input bit hit, input bit inv,
                            input addr_t a, input word_t d0, input word_t d1,
                            output int lat);
    bit p;
    int edges;
    p = !c;
    edges = 0;
    req[c].daddr = a;
    req[c].dren  = !wr;
    req[c].dwen  = wr;
    if (wr) begin
      req[c].dstore = d0;
    end else begin
      req[p].cctrans = hit;
      req[p].ccwrite = hit & inv;
      req[p].dstore  = d0;
    end
    wait_served(c, 1'b0, edges);
    req[c].daddr = a + 16'd1;
    if (wr)
      req[c].dstore = d1;
    else
      req[p].dstore = d1;
    wait_served(c, 1'b0, edges);
    req[c].dren    = 1'b0;
    req[c].dwen    = 1'b0;
    req[p].cctrans = 1'b0;
    req[p].ccwrite = 1'b0;
    lat = edges - 1;
  endtask

  task automatic expect_latency(input string what, input int got, input int exp);
    assert (got == exp)
    else begin
      $display("MISMATCH %s latency expected %h actual %h", what, exp, got);
      tb_error = 1'b1;
    end
  endtask

  initial begin : clock_gen
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin : stimulus
    word_t r;
    addr_t a;
    int    lat;
    int    lat2;

    seed   = 32'he3ccbef4;
    nRST   = 1'b0;
    req[0] = '0;
    req[1] = '0;
    repeat (2) @(posedge CLK);
    #DRIVE_DLY;
    nRST = 1'b1;
    @(posedge CLK);
    #DRIVE_DLY;

    // write-back from core 0, read back by both cores
    a = 16'h0040;
    data_block(1'b0, 1'b1, 1'b0, 1'b0, a, rand_word(), rand_word(), lat);
    expect_latency("write-back", lat, BLOCK_LAT);
    data_block(1'b0, 1'b0, 1'b0, 1'b0, a, '0, '0, lat);
    expect_latency("miss", lat, BLOCK_LAT);
    data_block(1'b1, 1'b0, 1'b0, 1'b0, a, '0, '0, lat);

    // core 1 takes the line from core 0, ram keeps the old words
    data_block(1'b1, 1'b0, 1'b1, 1'b0, a, rand_word(), rand_word(), lat);
    expect_latency("cache-to-cache", lat, 4);
    data_block(1'b1, 1'b0, 1'b0, 1'b0, a, '0, '0, lat);

    fetch_word(1'b0, a, lat);
    expect_latency("fetch", lat, RAM_LAT + 1);
    fork
      fetch_word(1'b0, a + 16'd1, lat);
      fetch_word(1'b1, a, lat2);
    join
    expect_latency("core 0 fetch", lat, RAM_LAT + 1);
    expect_latency("core 1 fetch", lat2, 2 * (RAM_LAT + 1));
    fork
      data_block(1'b0, 1'b0, 1'b0, 1'b0, a + 16'd1, '0, '0, lat);
      fetch_word(1'b1, a, lat2);
    join
    expect_latency("miss beside a fetch", lat, BLOCK_LAT);

    // every cctrans and ccwrite combination on both cores
    for (int i = 0; i < 16; i++) begin
      req[0].cctrans = i[0];
      req[0].ccwrite = i[1];
      req[1].cctrans = i[2];
      req[1].ccwrite = i[3];
      @(posedge CLK);
      #DRIVE_DLY;
    end
    req[0].cctrans = 1'b0;
    req[0].ccwrite = 1'b0;
    req[1].cctrans = 1'b0;
    req[1].ccwrite = 1'b0;

    for (int n = 0; n < N_RANDOM; n++) begin
      r = rand_word();
      a = addr_t'(r[31:16]) & ADDR_MASK;
      fork
        begin
          if (r[2:1] == 2'd0)
            fetch_word(r[0], a, lat);
          else
            data_block(r[0], r[2:1] == 2'd3, r[3], r[4], a, rand_word(), rand_word(), lat);
        end
        begin
          // the other core sometimes fetches alongside
          if (r[5])
            fetch_word(!r[0], rand_addr(), lat2);
        end
      join
    end
    tests_done = 1'b1;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    tb_error = 1'b1;
  end

  initial begin : finish_run
    wait (tests_done || chk_failed || tb_error);
    if (chk_failed || tb_error) begin
      $display("** FAIL **");
      $fatal(1, "stopped at the first error");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule
